/* sys_cont_pkg.sv */
`default_nettype none

// interrupt side types and IDT defaults.
package sys_cont_pkg;

  localparam int num_int = 4;

  typedef logic [$clog2(num_int)-1:0] int_idx_t;
  typedef logic [num_int-1:0]         int_vec_t;

  // line 0 sits in the low slot.
  localparam logic [num_int-1:0][31:0] idt_reset_addr = {
    32'h0000_f000,
    32'h0000_c000,
    32'h0000_8000,
    32'h0000_4000
  };

  // one bit per pipeline stage.
  typedef struct packed {
    logic fetch;
    logic decode_0;
    logic decode_1;
    logic register;
    logic address;
    logic execute;
    logic writeback;
  } flush_t;

  typedef struct packed {
    logic        valid;
    int_idx_t    index;
    logic [31:0] address;   // new entry address.
  } idt_cfg_t;

endpackage

`default_nettype wire

/* sys_mem_pkg.sv */
`default_nettype none

package sys_mem_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;

  // code segment width, low half of the second entry word.
  localparam int seg_w = 16;

  localparam int entry_stride = 4;  // byte offset of word 1.

  typedef struct packed {
    logic [addr_w-1:0] address;
  } mem_req_t;

  typedef struct packed {
    logic [data_w-1:0] read_data;
  } mem_rsp_t;

endpackage

`default_nettype wire

/* int_latch.sv */
`timescale 1ns/100ps
`default_nettype none

module int_latch (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire sys_cont_pkg::int_vec_t int_vec,
  input  wire logic                   int_clear,
  output logic                        pending_any,
  output sys_cont_pkg::int_idx_t      sel_idx
);

  import sys_cont_pkg::*;

  int_vec_t pending_q;
  int_vec_t clear_mask;
  logic     busy_q;     // a line is in service.
  int_idx_t held_q;     // winner frozen at service start.

  // drop the line held at service start.
  always_comb begin
    clear_mask = '0;
    if (int_clear) begin
      clear_mask[held_q] = 1'b1;
    end
  end

  // follows the controller leaving and reentering idle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      held_q <= '0;
    end else if (int_clear) begin
      busy_q <= 1'b0;
    end else if (!busy_q && pending_any) begin
      busy_q <= 1'b1;
      held_q <= sel_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q | int_vec) & ~clear_mask;  // clear wins.
    end
  end

  // lowest-numbered line wins.
  always_comb begin
    sel_idx = '0;
    for (int i = num_int - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        sel_idx = int_idx_t'(i);
      end
    end
  end

  assign pending_any = |pending_q;

endmodule

`default_nettype wire

/* idt_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module idt_regs (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire sys_cont_pkg::idt_cfg_t     idt_cfg,
  input  wire sys_cont_pkg::int_idx_t     sel_idx,
  output logic [sys_mem_pkg::addr_w-1:0]  entry_addr
);

  import sys_cont_pkg::*;
  import sys_mem_pkg::*;

  logic [num_int-1:0][addr_w-1:0] entry_q;   // one entry per line.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      entry_q <= idt_reset_addr;
    end else if (idt_cfg.valid) begin
      entry_q[idt_cfg.index] <= idt_cfg.address;
    end
  end

  // selected line's entry.
  assign entry_addr = entry_q[sel_idx];

endmodule

`default_nettype wire

/* int_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module int_controller (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        pending_any,
  input  wire logic [sys_mem_pkg::addr_w-1:0] entry_addr,
  output logic                             mem_valid,
  input  wire logic                        mem_ready,
  output sys_mem_pkg::mem_req_t            mem_req,
  input  wire logic                        mem_dp_valid,
  output logic                             mem_dp_ready,
  input  wire sys_mem_pkg::mem_rsp_t       mem_dp_rsp,
  output sys_cont_pkg::flush_t             flush,
  output logic                             fetch_load,
  output logic [sys_mem_pkg::addr_w-1:0]   fetch_load_address,
  output logic                             reg_load_cs,
  output logic [sys_mem_pkg::seg_w-1:0]    reg_cs,
  output logic                             decode_start_int,
  input  wire logic                        decode_end_int,
  output logic                             int_clear
);

  import sys_mem_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_flush,
    st_req_hdl,
    st_wait_hdl,
    st_req_seg,
    st_wait_seg,
    st_load,
    st_wait_dec
  } state_t;

  state_t            state_q;
  state_t            state_d;
  logic [addr_w-1:0] entry_q;     // entry of the line in service.
  logic [data_w-1:0] handler_q;
  logic [seg_w-1:0]  seg_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (pending_any) begin
          state_d = st_flush;
        end
      end
      st_flush: begin
        state_d = st_req_hdl;
      end
      st_req_hdl: begin
        if (mem_ready) begin
          state_d = st_wait_hdl;
        end
      end
      st_wait_hdl: begin
        if (mem_dp_valid) begin
          state_d = st_req_seg;
        end
      end
      st_req_seg: begin
        if (mem_ready) begin
          state_d = st_wait_seg;
        end
      end
      st_wait_seg: begin
        if (mem_dp_valid) begin
          state_d = st_load;
        end
      end
      st_load: begin
        state_d = st_wait_dec;
      end
      st_wait_dec: begin
        if (decode_end_int) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == st_idle && pending_any) begin
      entry_q <= entry_addr;   // freeze the winner's entry.
    end
    if (state_q == st_wait_hdl && mem_dp_valid) begin
      handler_q <= mem_dp_rsp.read_data;
    end
    if (state_q == st_wait_seg && mem_dp_valid) begin
      seg_q <= mem_dp_rsp.read_data[seg_w-1:0];
    end
  end

  // request address stays put until accepted.
  always_comb begin
    mem_req.address = entry_q;
    if (state_q == st_req_seg) begin
      mem_req.address = entry_q + addr_w'(entry_stride);
    end
  end

  assign mem_valid    = (state_q == st_req_hdl) || (state_q == st_req_seg);
  assign mem_dp_ready = (state_q == st_wait_hdl) || (state_q == st_wait_seg);

  assign flush = (state_q == st_flush) ? '1 : '0;  // all stages at once.

  assign fetch_load         = (state_q == st_load);
  assign reg_load_cs        = (state_q == st_load);
  assign decode_start_int   = (state_q == st_load);
  assign fetch_load_address = handler_q;
  assign reg_cs             = seg_q;

  assign int_clear = (state_q == st_wait_dec) && decode_end_int;

endmodule

`default_nettype wire

/* sys_cont_top.sv */
`timescale 1ns/100ps
`default_nettype none

module sys_cont_top (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire sys_cont_pkg::int_vec_t      int_vec,
  input  wire sys_cont_pkg::idt_cfg_t      idt_cfg,
  output logic                             mem_valid,
  input  wire logic                        mem_ready,
  output sys_mem_pkg::mem_req_t            mem_req,
  input  wire logic                        mem_dp_valid,
  output logic                             mem_dp_ready,
  input  wire sys_mem_pkg::mem_rsp_t       mem_dp_rsp,
  output sys_cont_pkg::flush_t             flush,
  output logic                             fetch_load,
  output logic [sys_mem_pkg::addr_w-1:0]   fetch_load_address,
  output logic                             reg_load_cs,
  output logic [sys_mem_pkg::seg_w-1:0]    reg_cs,
  output logic                             decode_start_int,
  input  wire logic                        decode_end_int
);

  import sys_cont_pkg::*;
  import sys_mem_pkg::*;

  logic              pending_any;
  logic              int_clear;
  int_idx_t          sel_idx;
  logic [addr_w-1:0] entry_addr;

  int_latch u_int_latch (
    .clk         (clk),
    .rst_n       (rst_n),
    .int_vec     (int_vec),
    .int_clear   (int_clear),
    .pending_any (pending_any),
    .sel_idx     (sel_idx)
  );

  idt_regs u_idt_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .idt_cfg    (idt_cfg),
    .sel_idx    (sel_idx),
    .entry_addr (entry_addr)
  );

  int_controller u_int_controller (
    .clk                (clk),
    .rst_n              (rst_n),
    .pending_any        (pending_any),
    .entry_addr         (entry_addr),
    .mem_valid          (mem_valid),
    .mem_ready          (mem_ready),
    .mem_req            (mem_req),
    .mem_dp_valid       (mem_dp_valid),
    .mem_dp_ready       (mem_dp_ready),
    .mem_dp_rsp         (mem_dp_rsp),
    .flush              (flush),
    .fetch_load         (fetch_load),
    .fetch_load_address (fetch_load_address),
    .reg_load_cs        (reg_load_cs),
    .reg_cs             (reg_cs),
    .decode_start_int   (decode_start_int),
    .decode_end_int     (decode_end_int),
    .int_clear          (int_clear)
  );

endmodule

`default_nettype wire

/* sys_cont_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module sys_cont_assertions (
  input wire logic                  clk,
  input wire logic                  rst_n,
  input wire logic                  mem_valid,
  input wire logic                  mem_ready,
  input wire sys_mem_pkg::mem_req_t mem_req,
  input wire logic                  mem_dp_ready,
  input wire sys_cont_pkg::flush_t  flush,
  input wire logic                  fetch_load,
  input wire logic                  decode_start_int
);

  // request held while the memory stalls.
  req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
    else $error("memory request changed under back-pressure");

  dp_ready_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_dp_ready && mem_valid))
    else $error("response ready raised while a request is open");

  // flush only right after an idle cycle.
  flush_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
    (|flush) |-> (&flush) && $past(!mem_valid && !mem_dp_ready && !fetch_load &&
                                   !decode_start_int && !(|flush)))
    else $error("flush pulse outside idle");

  flush_then_req_a: assert property (@(posedge clk) disable iff (!rst_n)
    (|flush) |=> !(|flush) && mem_valid)
    else $error("no memory request right after flush");

endmodule

`default_nettype wire

/* tb_sys_cont_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_sys_cont_top;

  import sys_cont_pkg::*;
  import sys_mem_pkg::*;

  localparam int rec_w     = 8;   // words per test line.
  localparam int max_tests = 64;
  localparam int clk_half  = 5;

  logic                clk = 1'b0;
  logic                rst_n = 1'b0;
  int_vec_t            int_vec = '0;
  idt_cfg_t            idt_cfg = '0;
  logic                mem_valid;
  logic                mem_ready = 1'b0;
  mem_req_t            mem_req;
  logic                mem_dp_valid = 1'b0;
  logic                mem_dp_ready;
  mem_rsp_t            mem_dp_rsp = '0;
  flush_t              flush;
  logic                fetch_load;
  logic [addr_w-1:0]   fetch_load_address;
  logic                reg_load_cs;
  logic [seg_w-1:0]    reg_cs;
  logic                decode_start_int;
  logic                decode_end_int = 1'b0;

  // values for the next rising edge.
  int_vec_t            int_vec_nxt = '0;
  idt_cfg_t            idt_cfg_nxt = '0;
  logic                mem_ready_nxt = 1'b0;
  logic                mem_dp_valid_nxt = 1'b0;
  mem_rsp_t            mem_dp_rsp_nxt = '0;
  logic                decode_end_nxt = 1'b0;

  logic [31:0]         tests_mem [0:max_tests*rec_w-1];
  logic [31:0]         tb_idt [0:num_int-1];  // reference IDT copy.
  int_vec_t            pending_m = '0;
  logic [31:0]         rng_state = 32'h6306764b;
  int                  num_tests = 0;
  logic                tests_loaded = 1'b0;
  int                  checks = 0;
  int                  value_errors = 0;
  int                  other_errors = 0;

  sys_cont_top u_sys_cont_top (.*);

  bind sys_cont_top sys_cont_assertions u_sys_cont_assertions (.*);

  initial begin
    forever #clk_half clk = ~clk;
  end

  always @(posedge clk) begin
    int_vec        <= int_vec_nxt;
    idt_cfg        <= idt_cfg_nxt;
    mem_ready      <= mem_ready_nxt;
    mem_dp_valid   <= mem_dp_valid_nxt;
    mem_dp_rsp     <= mem_dp_rsp_nxt;
    decode_end_int <= decode_end_nxt;
  end

  initial begin
    wait (tests_loaded);
    repeat (num_tests * 200) @(posedge clk);
    $display("watchdog expired after %0d cycles", num_tests * 200);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int extra_stall();
    rng_state = xorshift32(rng_state);
    return int'(rng_state[1:0]);  // 0 to 3 cycles.
  endfunction

  // first set bit from line 0 upwards.
  function automatic int_idx_t lowest_pending(input int_vec_t v);
    for (int i = 0; i < num_int; i++) begin
      if (v[i]) begin
        return int_idx_t'(i);
      end
    end
    return '0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic wait_cycle();
    @(negedge clk);
  endtask

  task automatic mem_request(input logic [31:0] exp_addr, input int stall);
    int n;
    n = stall + extra_stall();
    check_value("mem_valid", 32'd1, 32'(mem_valid));
    check_value("mem_req.address", exp_addr, mem_req.address);
    repeat (n) begin
      wait_cycle();
      check_value("mem_valid", 32'd1, 32'(mem_valid));
      check_value("mem_req.address", exp_addr, mem_req.address);  // held while stalled.
    end
    mem_ready_nxt = 1'b1;
    wait_cycle();
    check_value("mem_req.address", exp_addr, mem_req.address);
    check_value("mem_dp_ready", 32'd0, 32'(mem_dp_ready));
    mem_ready_nxt = 1'b0;
    wait_cycle();
  endtask

  task automatic mem_response(input logic [31:0] word, input int stall);
    int n;
    n = stall + extra_stall();
    check_value("mem_valid", 32'd0, 32'(mem_valid));
    check_value("mem_dp_ready", 32'd1, 32'(mem_dp_ready));
    repeat (n) begin
      wait_cycle();
      check_value("mem_dp_ready", 32'd1, 32'(mem_dp_ready));
    end
    mem_dp_valid_nxt = 1'b1;
    mem_dp_rsp_nxt.read_data = word;
    wait_cycle();
    check_value("mem_dp_ready", 32'd1, 32'(mem_dp_ready));
    mem_dp_valid_nxt = 1'b0;
    mem_dp_rsp_nxt = '0;
    wait_cycle();
  endtask

  task automatic service_line(input int_idx_t idx, input logic [31:0] hdl,
                              input logic [31:0] seg, input int rstall, input int dstall,
                              input int ddelay, input int_vec_t late);
    int n;
    n = 0;
    while (flush == '0 && n < 20) begin
      wait_cycle();
      n++;
    end
    assert (n < 20) else begin
      $display("no flush pulse within 20 cycles for line %0d", idx);
      other_errors++;
    end
    check_value("flush", 32'h7f, 32'(flush));
    wait_cycle();
    check_value("flush", 32'd0, 32'(flush));
    mem_request(tb_idt[idx], rstall);
    mem_response(hdl, dstall);
    mem_request(tb_idt[idx] + 32'd4, rstall);
    mem_response(seg, dstall);
    check_value("fetch_load", 32'd1, 32'(fetch_load));
    check_value("reg_load_cs", 32'd1, 32'(reg_load_cs));
    check_value("decode_start_int", 32'd1, 32'(decode_start_int));
    check_value("fetch_load_address", hdl, fetch_load_address);
    check_value("reg_cs", {16'h0, seg[15:0]}, 32'(reg_cs));
    wait_cycle();
    check_value("fetch_load", 32'd0, 32'(fetch_load));
    check_value("reg_load_cs", 32'd0, 32'(reg_load_cs));
    check_value("decode_start_int", 32'd0, 32'(decode_start_int));
    int_vec_nxt = late;  // raised during service.
    pending_m = pending_m | late;
    wait_cycle();
    int_vec_nxt = '0;
    repeat (ddelay) begin
      check_value("flush", 32'd0, 32'(flush));
      wait_cycle();
    end
    decode_end_nxt = 1'b1;
    wait_cycle();
    decode_end_nxt = 1'b0;
    pending_m[idx] = 1'b0;
    wait_cycle();
    check_value("flush", 32'd0, 32'(flush));
  endtask

  task automatic apply_cfg(input int_idx_t idx, input logic [31:0] addr);
    idt_cfg_nxt.valid   = 1'b1;
    idt_cfg_nxt.index   = idx;
    idt_cfg_nxt.address = addr;
    wait_cycle();
    idt_cfg_nxt.valid = 1'b0;
    wait_cycle();
    tb_idt[idx] = addr;
    check_value("flush", 32'd0, 32'(flush));
  endtask

  task automatic run_irq(input int base);
    int_vec_t mask;
    int_vec_t late;
    int_idx_t idx;
    mask = tests_mem[base+1][num_int-1:0];
    late = tests_mem[base+7][num_int-1:0];
    pending_m = pending_m | mask;
    int_vec_nxt = mask;
    wait_cycle();
    int_vec_nxt = '0;
    while (pending_m != '0) begin
      idx = lowest_pending(pending_m);
      // each line answers with its own words.
      service_line(idx, tests_mem[base+2] + 32'(idx), tests_mem[base+3] + 32'(idx),
                   int'(tests_mem[base+4]), int'(tests_mem[base+5]),
                   int'(tests_mem[base+6]), late);
      late = '0;
    end
  endtask

  initial begin
    int i;
    int base;
    for (i = 0; i < max_tests * rec_w; i++) begin
      tests_mem[i] = '0;
    end
    $readmemh("sys_cont_tests.txt", tests_mem);
    while (num_tests < max_tests && tests_mem[num_tests*rec_w] != 0) begin
      num_tests++;
    end
    tb_idt[0] = 32'h0000_4000;
    tb_idt[1] = 32'h0000_8000;
    tb_idt[2] = 32'h0000_c000;
    tb_idt[3] = 32'h0000_f000;
    tests_loaded = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    wait_cycle();
    check_value("mem_valid", 32'd0, 32'(mem_valid));
    check_value("mem_dp_ready", 32'd0, 32'(mem_dp_ready));
    check_value("flush", 32'd0, 32'(flush));
    check_value("fetch_load", 32'd0, 32'(fetch_load));
    check_value("reg_load_cs", 32'd0, 32'(reg_load_cs));
    check_value("decode_start_int", 32'd0, 32'(decode_start_int));
    for (i = 0; i < num_tests; i++) begin
      base = i * rec_w;
      if (tests_mem[base] == 32'd1) begin
        apply_cfg(int_idx_t'(tests_mem[base+1]), tests_mem[base+2]);
      end else if (tests_mem[base] == 32'd2) begin
        run_irq(base);
      end else begin
        $display("unknown line kind %0h in test %0d", tests_mem[base], i);
        other_errors++;
      end
    end
    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sys_cont_tests.txt */
// kind idx_or_mask addr_or_handler segment rdy_stall rsp_stall dec_delay late_mask
// kind 1 writes IDT entry idx; kind 2 raises the mask and serves all pending lines
2 1 00100000 00000011 0 0 0 0
2 4 00200000 00000022 1 0 2 0
2 2 00300000 00010033 0 2 1 0
2 8 00400000 00000044 2 2 0 0
2 6 00500000 00ab0055 1 1 3 0
2 f 00600000 00000066 0 0 1 0
2 1 00700000 00000077 0 0 4 8
2 8 00800000 00000088 1 0 2 1
1 2 0001a000 00000000 0 0 0 0
2 2 00900000 00000099 0 1 0 0
1 0 00012340 00000000 0 0 0 0
2 5 00a00000 000000aa 2 0 1 2
1 3 0000fff0 00000000 0 0 0 0
2 c 00b00000 000000bb 0 3 2 0
1 1 00020000 00000000 0 0 0 0
2 2 00c00000 1234cccc 3 3 0 4
2 4 00d00000 000000dd 0 0 2 4
2 a 00e00000 5678eeee 1 2 1 1
2 1 00f00000 000000ff 4 0 0 0
2 3 01000000 00000100 0 4 3 c
2 9 01100000 00000110 2 1 0 0

/* sys_cont.f */
sys_cont_pkg.sv
sys_mem_pkg.sv
int_latch.sv
idt_regs.sv
int_controller.sv
sys_cont_top.sv
sys_cont_assertions.sv
tb_sys_cont_top.sv

/* Bender.yml */
package:
  name: sys_cont

sources:
  - sys_cont_pkg.sv
  - sys_mem_pkg.sv
  - int_latch.sv
  - idt_regs.sv
  - int_controller.sv
  - sys_cont_top.sv
  - target: simulation
    files:
      - sys_cont_assertions.sv
      - tb_sys_cont_top.sv
